/* compile.f */
+incdir+src
src/dataPkg.sv
src/accessPkg.sv
src/storeAlign.sv
src/loadExtract.sv
src/dataRam.sv
src/accessCtrl.sv
src/memAccessUnit.sv
dv/memAccessTb.sv

/* Makefile */
SIM = obj_dir/VmemAccessTb

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

$(SIM): compile.f $(wildcard src/*.sv src/*.svh dv/*.sv)
	verilator --binary --timing --assert -f compile.f --top-module memAccessTb

clean:
	rm -rf obj_dir

/* dv/memAccessTb.sv */
// one request at a time; every load hits bytes that an earlier store in the table wrote
`timescale 1ns/1ps
`include "memAccessSettings.svh"

module memAccessTb;
    import accessPkg::*;
    import dataPkg::*;

    localparam int refBytes = `MEM_DEPTH_WORDS * 8;

    logic       clk;
    logic       reset;
    logic       req;
    logic       ack;
    memOpT      memOp;
    byteAddrT   addr;
    doubleWordT wdata;
    logic       wen;
    doubleWordT rdata;

    // stimulus table, one entry per transaction
    string      stepName [$];
    memOpT      stepOp   [$];
    byteAddrT   stepAddr [$];
    doubleWordT stepData [$];
    logic       stepWen  [$];
    int         stepHold [$];  // cycles req stays high after ack
    bit         tableReady;

    logic [7:0]  refMem [0:refBytes-1];  // byte image of the RAM
    logic [31:0] lfsrState;
    int          dataErrors;
    int          ackErrors;

    memAccessUnit u_memAccessUnit (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ack   (ack),
        .memOp (memOp),
        .addr  (addr),
        .wdata (wdata),
        .wen   (wen),
        .rdata (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic doubleWordT randomWord();
        doubleWordT word;
        word = '0;
        for (int i = 0; i < 64; i++) begin
            word      = {word[62:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return word;
    endfunction

    function automatic int sizeBytes(input memOpT op);
        case (op[1:0])
            2'b01:   return 1;
            2'b10:   return 2;
            2'b11:   return 8;
            default: return 4;
        endcase
    endfunction

    // little endian gather, then sign or zero fill above the top byte
    function automatic doubleWordT expectedLoad(input memOpT op, input byteAddrT a);
        int         n;
        doubleWordT value;
        logic       fill;
        n     = sizeBytes(op);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[8*i +: 8] = refMem[int'(a) + i];
        end
        fill = ~op[2] & value[8*n - 1];
        for (int i = 8 * n; i < 64; i++) begin
            value[i] = fill;
        end
        return value;
    endfunction

    task automatic refStore(input memOpT op, input byteAddrT a, input doubleWordT data);
        for (int i = 0; i < sizeBytes(op); i++) begin
            refMem[int'(a) + i] = data[8*i +: 8];
        end
    endtask

    task automatic checkData(input string name, input doubleWordT expected,
                             input doubleWordT actual);
        if (actual !== expected) begin
            dataErrors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkAck(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            ackErrors++;
            $display("Fail %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic addStep(input string name, input memOpT op, input int a,
                           input doubleWordT data, input logic we, input int hold);
        stepName.push_back(name);
        stepOp.push_back(op);
        stepAddr.push_back(byteAddrT'(a));
        stepData.push_back(data);
        stepWen.push_back(we);
        stepHold.push_back(hold);
    endtask

    // one four-phase transaction, entered 2 ns after a rising edge
    task automatic runTransfer(input string name, input memOpT op, input byteAddrT a,
                               input doubleWordT data, input logic we, input int hold,
                               output doubleWordT result);
        memOp = op;
        addr  = a;
        wdata = data;
        wen   = we;
        req   = 1'b1;
        for (int cyc = 1; cyc <= 3; cyc++) begin
            @(posedge clk);
            #2;
            checkAck($sformatf("%s ack cycle %0d", name, cyc), cyc == 3, ack);
        end
        result = rdata;
        if (hold > 0) begin
            wdata = ~data;  // would show up if a second write slipped in
        end
        repeat (hold) begin
            @(posedge clk);
            #2;
            checkAck({name, " held ack"}, 1'b1, ack);
            checkData({name, " held rdata"}, result, rdata);
        end
        req = 1'b0;
        @(posedge clk);
        #2;
        checkAck({name, " ack after req drop"}, 1'b1, ack);
        @(posedge clk);
        #2;
        checkAck({name, " ack release"}, 1'b0, ack);
    endtask

    task automatic buildTable();
        int         dwAddr [4];
        doubleWordT signPattern;
        dwAddr      = '{'h000, 'h008, 'h1f8, 'h7f8};
        signPattern = 64'hf0e1_d2c3_7b6a_8594;

        // doubleword round trips
        foreach (dwAddr[i]) begin
            addStep($sformatf("sd 0x%03h", dwAddr[i]), 3'b011, dwAddr[i], randomWord(), 1'b1, 0);
        end
        foreach (dwAddr[i]) begin
            addStep($sformatf("ld 0x%03h", dwAddr[i]), 3'b011, dwAddr[i], '0, 1'b0, 0);
        end
        addStep("ld code 111 0x008", 3'b111, 'h008, '0, 1'b0, 0);

        // partial stores, full word read back after each
        addStep("fill 0x100", 3'b011, 'h100, randomWord(), 1'b1, 0);
        for (int off = 0; off < 8; off++) begin
            addStep($sformatf("sb off %0d", off), 3'b001, 'h100 + off, randomWord(), 1'b1, 0);
            addStep($sformatf("ld after sb off %0d", off), 3'b011, 'h100, '0, 1'b0, 0);
        end
        addStep("fill 0x108", 3'b011, 'h108, randomWord(), 1'b1, 0);
        for (int off = 0; off < 8; off += 2) begin
            addStep($sformatf("sh off %0d", off), 3'b010, 'h108 + off, randomWord(), 1'b1, 0);
            addStep($sformatf("ld after sh off %0d", off), 3'b011, 'h108, '0, 1'b0, 0);
        end
        addStep("fill 0x110", 3'b011, 'h110, randomWord(), 1'b1, 0);
        for (int off = 0; off < 8; off += 4) begin
            addStep($sformatf("sw off %0d", off), 3'b000, 'h110 + off, randomWord(), 1'b1, 0);
            addStep($sformatf("ld after sw off %0d", off), 3'b011, 'h110, '0, 1'b0, 0);
        end

        // mixed sign bits per lane
        addStep("sign pattern 0x200", 3'b011, 'h200, signPattern, 1'b1, 0);
        for (int off = 0; off < 8; off++) begin
            addStep($sformatf("lb off %0d", off), 3'b001, 'h200 + off, '0, 1'b0, 0);
            addStep($sformatf("lbu off %0d", off), 3'b101, 'h200 + off, '0, 1'b0, 0);
        end
        for (int off = 0; off < 8; off += 2) begin
            addStep($sformatf("lh off %0d", off), 3'b010, 'h200 + off, '0, 1'b0, 0);
            addStep($sformatf("lhu off %0d", off), 3'b110, 'h200 + off, '0, 1'b0, 0);
        end
        for (int off = 0; off < 8; off += 4) begin
            addStep($sformatf("lw off %0d", off), 3'b000, 'h200 + off, '0, 1'b0, 0);
            addStep($sformatf("lwu off %0d", off), 3'b100, 'h200 + off, '0, 1'b0, 0);
        end

        // back-pressure
        addStep("held sd 0x300", 3'b011, 'h300, randomWord(), 1'b1, 4);
        addStep("held ld 0x300", 3'b011, 'h300, '0, 1'b0, 4);
        addStep("held sb 0x303", 3'b001, 'h303, randomWord(), 1'b1, 3);
        addStep("readback 0x300", 3'b011, 'h300, '0, 1'b0, 0);
    endtask

    // watchdog
    initial begin
        int limit;
        wait (tableReady);
        limit = stepName.size() * 10 + 50;
        repeat (limit) @(posedge clk);
        $display("timeout: the table did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        doubleWordT result;
        doubleWordT expected;
        reset      = 1'b1;
        req        = 1'b0;
        memOp      = '0;
        addr       = '0;
        wdata      = '0;
        wen        = 1'b0;
        dataErrors = 0;
        ackErrors  = 0;
        lfsrState  = 32'h10e9_22c2;
        tableReady = 1'b0;
        buildTable();
        tableReady = 1'b1;

        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        checkAck("reset ack", 1'b0, ack);
        checkData("reset rdata", '0, rdata);

        for (int k = 0; k < stepName.size(); k++) begin
            expected = expectedLoad(stepOp[k], stepAddr[k]);
            runTransfer(stepName[k], stepOp[k], stepAddr[k], stepData[k], stepWen[k],
                        stepHold[k], result);
            if (stepWen[k]) begin
                refStore(stepOp[k], stepAddr[k], stepData[k]);
            end else begin
                checkData(stepName[k], expected, result);
            end
        end

        $display("%0d transactions, %0d data errors, %0d handshake errors",
                 stepName.size(), dataErrors, ackErrors);
        if (dataErrors == 0 && ackErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src/memAccessUnit.sv */
// data memory access block; aligned accesses only, one request in flight
`timescale 1ns/1ps
`include "memAccessSettings.svh"

module memAccessUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    output logic                ack,
    input  accessPkg::memOpT    memOp,
    input  dataPkg::byteAddrT   addr,
    input  dataPkg::doubleWordT wdata,
    input  logic                wen,
    output dataPkg::doubleWordT rdata
);
    import accessPkg::*;
    import dataPkg::*;

    memOpT      latchedOp;
    byteOffsetT offset;
    wordIndexT  wordIdx;
    logic       ramEn;
    logic       ramWen;
    doubleWordT wdataReg;
    doubleWordT alignedData;
    byteMaskT   byteMask;
    doubleWordT ramRdata;
    doubleWordT loadData;

    // wdata is held by the requester until ack, so sampling while waiting is safe
    always_ff @(posedge clk) begin
        if (req && !ack) begin
            wdataReg <= wdata;
        end
    end

    accessCtrl u_accessCtrl (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .ack       (ack),
        .memOp     (memOp),
        .addr      (addr),
        .wen       (wen),
        .latchedOp (latchedOp),
        .offset    (offset),
        .wordIdx   (wordIdx),
        .ramEn     (ramEn),
        .ramWen    (ramWen),
        .loadData  (loadData),
        .rdata     (rdata)
    );

    storeAlign u_storeAlign (
        .memOp       (latchedOp),
        .offset      (offset),
        .wdata       (wdataReg),
        .alignedData (alignedData),
        .byteMask    (byteMask)
    );

    dataRam #(
        .depthWords (`MEM_DEPTH_WORDS)
    ) u_dataRam (
        .clk      (clk),
        .en       (ramEn),
        .wen      (ramWen),
        .wordIdx  (wordIdx),
        .byteMask (byteMask),
        .wdata    (alignedData),
        .rdata    (ramRdata)
    );

    loadExtract u_loadExtract (
        .memOp    (latchedOp),
        .offset   (offset),
        .ramRdata (ramRdata),
        .loadData (loadData)
    );

endmodule

/* src/accessCtrl.sv */
// one request at a time; ack comes 3 cycles after req and holds until req drops
`timescale 1ns/1ps

module accessCtrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  accessPkg::memOpT      memOp,
    input  dataPkg::byteAddrT     addr,
    input  logic                  wen,
    output accessPkg::memOpT      latchedOp,
    output accessPkg::byteOffsetT offset,
    output dataPkg::wordIndexT    wordIdx,
    output logic                  ramEn,
    output logic                  ramWen,
    input  dataPkg::doubleWordT   loadData,
    output dataPkg::doubleWordT   rdata
);
    import accessPkg::*;
    import dataPkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stAccess,   // RAM enabled this cycle
        stCapture,  // RAM word valid
        stDone,     // ack high until req drops
        stRelease
    } ctrlStateT;

    ctrlStateT state;
    logic      latchedWen;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= stIdle;
            ack    <= 1'b0;
            ramEn  <= 1'b0;
            ramWen <= 1'b0;
            rdata  <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (req) begin
                        ramEn  <= 1'b1;
                        ramWen <= wen;
                        state  <= stAccess;
                    end
                end
                stAccess: begin
                    ramEn  <= 1'b0;  // single cycle pulse
                    ramWen <= 1'b0;
                    state  <= stCapture;
                end
                stCapture: begin
                    ack <= 1'b1;
                    if (!latchedWen) begin
                        rdata <= loadData;
                    end
                    state <= stDone;
                end
                stDone: begin
                    if (!req) begin
                        state <= stRelease;
                    end
                end
                stRelease: begin
                    ack   <= 1'b0;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // request fields, taken once per transaction
    always_ff @(posedge clk) begin
        if (state == stIdle && req) begin
            latchedOp  <= memOp;
            offset     <= addr[2:0];
            wordIdx    <= wordIndexT'(addr >> 3);
            latchedWen <= wen;
        end
    end

    // requester may not drop req before ack arrives
    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        (!req && !ack) |=> !ack)
        else $error("ack raised while req was low");

    reqFieldsStable: assert property (@(posedge clk) disable iff (reset)
        (req && !ack) |=> (!req || ($stable(memOp) && $stable(addr) && $stable(wen))))
        else $error("request fields changed before ack");

endmodule

/* src/dataRam.sv */
// single port, one access per enabled cycle; reads return on the next cycle
`timescale 1ns/1ps
`include "memAccessSettings.svh"

module dataRam #(
    parameter int depthWords = `MEM_DEPTH_WORDS
) (
    input  logic                clk,
    input  logic                en,
    input  logic                wen,
    input  dataPkg::wordIndexT  wordIdx,
    input  dataPkg::byteMaskT   byteMask,
    input  dataPkg::doubleWordT wdata,
    output dataPkg::doubleWordT rdata
);
    import dataPkg::*;

    localparam int idxBits = $clog2(depthWords);

    doubleWordT             mem [0:depthWords-1];
    logic [idxBits-1:0]     ramIdx;

    assign ramIdx = wordIdx[idxBits-1:0];  // upper bits checked below

    always_ff @(posedge clk) begin
        if (en) begin
            if (wen) begin
                for (int i = 0; i < 8; i++) begin
                    if (byteMask[i]) begin
                        mem[ramIdx][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[ramIdx];
            end
        end
    end

    // addresses past the RAM would alias onto low words
    idxInRange: assert property (@(posedge clk)
        en |-> (32'(wordIdx) < depthWords))
        else $error("word index %0d outside RAM of %0d words", wordIdx, depthWords);

endmodule

/* src/loadExtract.sv */
// combinational; assumes the offset is aligned to the access size
`timescale 1ns/1ps

module loadExtract (
    input  accessPkg::memOpT      memOp,
    input  accessPkg::byteOffsetT offset,
    input  dataPkg::doubleWordT   ramRdata,
    output dataPkg::doubleWordT   loadData
);
    import accessPkg::*;
    import dataPkg::*;

    accessSizeT size;
    doubleWordT shifted;    // addressed lanes moved down to byte 0
    logic       signFill;
    logic       topBit;

    assign size     = memOp[1:0];
    assign shifted  = ramRdata >> {offset, 3'b000};
    assign signFill = ~memOp[2] & topBit;  // bit 2 set means zero extend

    // msb of the loaded value
    always_comb begin
        case (size)
            sizeByte: topBit = shifted[7];
            sizeHalf: topBit = shifted[15];
            sizeWord: topBit = shifted[31];
            default:  topBit = shifted[63];
        endcase
    end

    always_comb begin
        case (size)
            sizeByte: begin
                loadData = {{56{signFill}}, shifted[7:0]};
            end
            sizeHalf: begin
                loadData = {{48{signFill}}, shifted[15:0]};
            end
            sizeWord: begin
                loadData = {{32{signFill}}, shifted[31:0]};
            end
            default: begin
                // 3'b011 and 3'b111 give the same full word
                loadData = shifted;
            end
        endcase
    end

endmodule

/* src/storeAlign.sv */
// combinational; a misaligned offset is flagged and its upper lanes fall off the word
`timescale 1ns/1ps

module storeAlign (
    input  accessPkg::memOpT      memOp,
    input  accessPkg::byteOffsetT offset,
    input  dataPkg::doubleWordT   wdata,
    output dataPkg::doubleWordT   alignedData,
    output dataPkg::byteMaskT     byteMask
);
    import accessPkg::*;
    import dataPkg::*;

    accessSizeT size;
    byteMaskT   laneMask;   // lanes written when offset is 0
    byteOffsetT alignBits;  // offset bits that must be zero
    doubleWordT keepData;

    assign size = memOp[1:0];

    always_comb begin
        case (size)
            sizeByte: begin
                laneMask  = 8'h01;
                alignBits = 3'b000;
            end
            sizeHalf: begin
                laneMask  = 8'h03;
                alignBits = 3'b001;
            end
            sizeWord: begin
                laneMask  = 8'h0f;
                alignBits = 3'b011;
            end
            sizeDouble: begin
                laneMask  = 8'hff;
                alignBits = 3'b111;
            end
        endcase
    end

    // clear the lanes above the access size before shifting
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            keepData[8*i +: 8] = laneMask[i] ? wdata[8*i +: 8] : 8'h00;
        end
    end

    assign alignedData = keepData << {offset, 3'b000};
    assign byteMask    = laneMask << offset;

    // loads pass through here too, so this covers every access
    always_comb begin
        if (!$isunknown({memOp, offset})) begin
            assert ((offset & alignBits) == 3'b000)
                else $error("misaligned access, offset %0d size code %0d", offset, size);
        end
    end

endmodule

/* src/accessPkg.sv */
// access type encoding; bit 2 of memOp selects zero extension and only matters for loads
package accessPkg;

    // {unsigned, size}
    typedef logic [2:0] memOpT;

    typedef logic [1:0] accessSizeT;

    // byte position of the access inside its word
    typedef logic [2:0] byteOffsetT;

    // size field codes
    localparam accessSizeT sizeWord   = 2'b00;
    localparam accessSizeT sizeByte   = 2'b01;
    localparam accessSizeT sizeHalf   = 2'b10;
    localparam accessSizeT sizeDouble = 2'b11;

endpackage

/* src/dataPkg.sv */
// data path types; the data width is fixed at 64 bits with eight byte lanes
`include "memAccessSettings.svh"

package dataPkg;

    // one RAM word
    typedef logic [63:0] doubleWordT;

    typedef logic [`MEM_ADDR_BITS-1:0] byteAddrT;

    // one bit per byte lane, lane 0 is bits 7..0
    typedef logic [7:0] byteMaskT;

    // byte address with the low 3 bits dropped
    typedef logic [`MEM_ADDR_BITS-4:0] wordIndexT;

endpackage

/* src/memAccessSettings.svh */
// build-wide defaults; the RAM must fit inside the byte address space
`ifndef MEM_ACCESS_SETTINGS_SVH
`define MEM_ACCESS_SETTINGS_SVH

// default number of 64-bit words in the data RAM
`define MEM_DEPTH_WORDS 256

// byte address width seen at the request port
`define MEM_ADDR_BITS 16

`endif
